// File: hdl/uart_pkg.sv
`default_nettype none

package uart_pkg;

    // ##################################################
    // Bit timing
    // ##################################################

    localparam int CLKS_PER_BIT = 8;                      // clk_uart cycles per bit.
    localparam int HALF_BIT     = CLKS_PER_BIT / 2;
    localparam int TIMER_W      = $clog2(CLKS_PER_BIT);

    // ##################################################
    // Frame format
    // ##################################################

    localparam int DATA_BITS  = 8;
    localparam int FRAME_BITS = DATA_BITS + 2;            // Start, data, stop.

    localparam logic START_BIT = 1'b0;
    localparam logic STOP_BIT  = 1'b1;

    typedef logic [DATA_BITS-1:0] uart_byte_t;

    // Receiver output.
    typedef struct packed {
        uart_byte_t data;
        logic       frame_err;                            // Stop bit sampled low.
    } rx_result_t;

endpackage

`default_nettype wire

// File: hdl/flag_sync.sv
`default_nettype none

module flag_sync (
    input  wire  clk_a,
    input  wire  clk_b,
    input  wire  rst_n,
    input  wire  flag_in,
    output logic flag_out
);

    logic       toggle_a;
    logic [2:0] sync_b;

    // Source side toggles once per pulse.
    always_ff @(posedge clk_a or negedge rst_n) begin
        if (!rst_n) begin
            toggle_a <= 1'b0;
        end else if (flag_in) begin
            toggle_a <= !toggle_a;
        end
    end

    // Two sync stages, third stage for edge detect.
    always_ff @(posedge clk_b or negedge rst_n) begin
        if (!rst_n) begin
            sync_b <= '0;
        end else begin
            sync_b <= {sync_b[1:0], toggle_a};
        end
    end

    assign flag_out = sync_b[2] ^ sync_b[1];  // Either edge is one event.

endmodule

`default_nettype wire

// File: hdl/cdc_handoff.sv
`default_nettype none

module cdc_handoff #(
    parameter type payload_t = logic [7:0]
) (
    input  wire           clk_src,
    input  wire           clk_dst,
    input  wire           rst_n,
    input  wire           src_valid,
    output logic          src_ready,
    input  wire payload_t src_data,
    output logic          dst_valid,
    input  wire           dst_ready,
    output payload_t      dst_data,
    output logic          drop
);

    logic     busy;
    logic     src_take;
    logic     dst_take;
    logic     req_dst;
    logic     ack_src;
    payload_t hold;

    // ##################################################
    // Source side
    // ##################################################

    assign src_ready = !busy;
    assign src_take  = src_valid && src_ready;
    assign drop      = src_valid && busy;     // Arrival with no room.

    always_ff @(posedge clk_src or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
        end else if (src_take) begin
            busy <= 1'b1;
        end else if (ack_src) begin
            busy <= 1'b0;
        end
    end

    // Stable until the acknowledge returns.
    always_ff @(posedge clk_src) begin
        if (src_take) begin
            hold <= src_data;
        end
    end

    flag_sync u_req_sync (
        .clk_a    (clk_src),
        .clk_b    (clk_dst),
        .rst_n    (rst_n),
        .flag_in  (src_take),
        .flag_out (req_dst)
    );

    // ##################################################
    // Destination side
    // ##################################################

    assign dst_take = dst_valid && dst_ready;
    assign dst_data = hold;

    always_ff @(posedge clk_dst or negedge rst_n) begin
        if (!rst_n) begin
            dst_valid <= 1'b0;
        end else if (req_dst) begin
            dst_valid <= 1'b1;
        end else if (dst_take) begin
            dst_valid <= 1'b0;
        end
    end

    flag_sync u_ack_sync (
        .clk_a    (clk_dst),
        .clk_b    (clk_src),
        .rst_n    (rst_n),
        .flag_in  (dst_take),
        .flag_out (ack_src)
    );

endmodule

`default_nettype wire

// File: hdl/uart_tx.sv
`default_nettype none

module uart_tx
    import uart_pkg::*;
(
    input  wire             clk_uart,
    input  wire             rst_n,
    input  wire             in_valid,
    output logic            in_ready,
    input  wire uart_byte_t in_data,
    output logic            done,
    output logic            txd
);

    localparam int CNT_W = $clog2(FRAME_BITS + 1);

    logic                  sending;
    logic                  accept;
    logic                  bit_edge;
    logic [CNT_W-1:0]      bits_left;
    logic [TIMER_W-1:0]    timer;
    logic [FRAME_BITS-1:0] shift_buf;

    assign in_ready = !sending;
    assign accept   = in_valid && in_ready;

    // Next bit goes out when the timer expires.
    assign bit_edge = sending && (timer == '0) && (bits_left != '0);

    always_ff @(posedge clk_uart or negedge rst_n) begin
        if (!rst_n) begin
            sending   <= 1'b0;
            bits_left <= '0;
            timer     <= '0;
            txd       <= STOP_BIT;               // Line idles high.
            done      <= 1'b0;
        end else begin
            done <= 1'b0;
            if (accept) begin
                sending   <= 1'b1;
                bits_left <= CNT_W'(FRAME_BITS);
                timer     <= '0;                 // Start bit on next cycle.
            end else if (bit_edge) begin
                txd       <= shift_buf[0];
                bits_left <= bits_left - 1'b1;
                timer     <= TIMER_W'(CLKS_PER_BIT - 1);
            end else if (sending) begin
                if (timer == '0) begin
                    // Stop bit has run its full period.
                    sending <= 1'b0;
                    done    <= 1'b1;
                    txd     <= STOP_BIT;
                end else begin
                    timer <= timer - 1'b1;
                end
            end
        end
    end

    // ##################################################
    // Shift buffer, LSB first
    // ##################################################

    always_ff @(posedge clk_uart) begin
        if (accept) begin
            shift_buf <= {STOP_BIT, in_data, START_BIT};
        end else if (bit_edge) begin
            shift_buf <= shift_buf >> 1;
        end
    end

endmodule

`default_nettype wire

// File: hdl/uart_rx.sv
`default_nettype none

module uart_rx
    import uart_pkg::*;
(
    input  wire        clk_uart,
    input  wire        rst_n,
    input  wire        rxd,
    output logic       out_valid,
    output rx_result_t out_data
);

    localparam int IDX_W = $clog2(DATA_BITS);

    typedef enum logic [2:0] {
        S_IDLE,
        S_START,
        S_DATA,
        S_STOP,
        S_WAIT_HIGH
    } state_t;

    state_t             state;
    logic               rx_meta;
    logic               rx_sync;
    logic               rx_prev;
    logic               fall;
    logic               tick;
    logic [TIMER_W-1:0] timer;
    logic [IDX_W-1:0]   bit_idx;
    uart_byte_t         shreg;

    // ##################################################
    // Line synchronizer and edge detect
    // ##################################################

    always_ff @(posedge clk_uart or negedge rst_n) begin
        if (!rst_n) begin
            rx_meta <= STOP_BIT;
            rx_sync <= STOP_BIT;
            rx_prev <= STOP_BIT;
        end else begin
            rx_meta <= rxd;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    assign fall = (rx_prev == STOP_BIT) && (rx_sync == START_BIT);
    assign tick = (timer == '0);                 // Sample point.

    // ##################################################
    // Frame FSM
    // ##################################################

    always_ff @(posedge clk_uart or negedge rst_n) begin
        if (!rst_n) begin
            state     <= S_IDLE;
            timer     <= '0;
            bit_idx   <= '0;
            out_valid <= 1'b0;
        end else begin
            out_valid <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (fall) begin
                        timer <= TIMER_W'(HALF_BIT - 1);
                        state <= S_START;
                    end
                end
                S_START: begin
                    if (!tick) begin
                        timer <= timer - 1'b1;
                    end else if (rx_sync == START_BIT) begin
                        timer   <= TIMER_W'(CLKS_PER_BIT - 1);
                        bit_idx <= '0;
                        state   <= S_DATA;
                    end else begin
                        state <= S_IDLE;             // Glitch, not a start bit.
                    end
                end
                S_DATA: begin
                    if (!tick) begin
                        timer <= timer - 1'b1;
                    end else begin
                        timer <= TIMER_W'(CLKS_PER_BIT - 1);
                        if (bit_idx == IDX_W'(DATA_BITS - 1)) begin
                            state <= S_STOP;
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                        end
                    end
                end
                S_STOP: begin
                    if (!tick) begin
                        timer <= timer - 1'b1;
                    end else begin
                        out_valid <= 1'b1;
                        state     <= (rx_sync == STOP_BIT) ? S_IDLE : S_WAIT_HIGH;
                    end
                end
                S_WAIT_HIGH: begin
                    if (rx_sync == STOP_BIT) begin
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // Data path.
    always_ff @(posedge clk_uart) begin
        if (state == S_DATA && tick) begin
            shreg <= {rx_sync, shreg[DATA_BITS-1:1]};
        end
        if (state == S_STOP && tick) begin
            out_data.data      <= shreg;
            out_data.frame_err <= (rx_sync != STOP_BIT);
        end
    end

endmodule

`default_nettype wire

// File: hdl/uart_status.sv
`default_nettype none

module uart_status
    import uart_pkg::*;
(
    input  wire             clk_bus,
    input  wire             rst_n,
    input  wire             res_valid,
    output logic            res_ready,
    input  wire rx_result_t res_data,
    input  wire             drop,
    input  wire             tx_pending,
    output logic            rx_valid,
    input  wire             rx_ready,
    output uart_byte_t      rx_data,
    output logic            rx_frame_err,
    input  wire             err_clear,
    output logic            tx_busy,
    output logic            overrun,
    output logic            frame_err
);

    rx_result_t entry;
    logic       arrive;
    logic       load;
    logic       discard;

    assign res_ready = 1'b1;                      // Never stalls the handoff.
    assign arrive    = res_valid && res_ready;
    assign load      = arrive && (!rx_valid || rx_ready);
    assign discard   = arrive && rx_valid && !rx_ready;

    // ##################################################
    // Holding register
    // ##################################################

    always_ff @(posedge clk_bus or negedge rst_n) begin
        if (!rst_n) begin
            rx_valid <= 1'b0;
        end else if (load) begin
            rx_valid <= 1'b1;
        end else if (rx_ready) begin
            rx_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk_bus) begin
        if (load) begin
            entry <= res_data;
        end
    end

    assign rx_data      = entry.data;
    assign rx_frame_err = entry.frame_err;

    // Sticky flags and busy.
    always_ff @(posedge clk_bus or negedge rst_n) begin
        if (!rst_n) begin
            overrun   <= 1'b0;
            frame_err <= 1'b0;
            tx_busy   <= 1'b0;
        end else begin
            tx_busy <= tx_pending;
            if (err_clear) begin
                overrun   <= 1'b0;
                frame_err <= 1'b0;
            end else begin
                if (discard || drop) overrun <= 1'b1;
                if (arrive && res_data.frame_err) frame_err <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/uart_core.sv
`default_nettype none

module uart_core
    import uart_pkg::*;
(
    input  wire             clk_bus,
    input  wire             clk_uart,
    input  wire             rst_n,
    input  wire             tx_valid,
    output logic            tx_ready,
    input  wire uart_byte_t tx_data,
    output logic            rx_valid,
    input  wire             rx_ready,
    output uart_byte_t      rx_data,
    output logic            rx_frame_err,
    input  wire             err_clear,
    output logic            tx_busy,
    output logic            overrun,
    output logic            frame_err,
    output logic            txd,
    input  wire             rxd
);

    logic       tx_src_ready;
    logic       tx_in_flight;
    logic       txq_valid;
    logic       txq_ready;
    uart_byte_t txq_data;
    logic       tx_done;
    logic       tx_done_bus;

    logic       rxr_valid;
    rx_result_t rxr_data;
    logic       rx_drop;
    logic       rx_drop_bus;
    logic       st_valid;
    logic       st_ready;
    rx_result_t st_data;

    // ##################################################
    // Transmit path
    // ##################################################

    assign tx_ready = tx_src_ready && !tx_in_flight;

    // Frame in flight until done comes back.
    always_ff @(posedge clk_bus or negedge rst_n) begin
        if (!rst_n) begin
            tx_in_flight <= 1'b0;
        end else if (tx_valid && tx_ready) begin
            tx_in_flight <= 1'b1;
        end else if (tx_done_bus) begin
            tx_in_flight <= 1'b0;
        end
    end

    cdc_handoff #(.payload_t(uart_byte_t)) u_tx_handoff (
        .clk_src   (clk_bus),
        .clk_dst   (clk_uart),
        .rst_n     (rst_n),
        .src_valid (tx_valid && tx_ready),
        .src_ready (tx_src_ready),
        .src_data  (tx_data),
        .dst_valid (txq_valid),
        .dst_ready (txq_ready),
        .dst_data  (txq_data),
        .drop      ()
    );

    uart_tx u_tx (
        .clk_uart (clk_uart),
        .rst_n    (rst_n),
        .in_valid (txq_valid),
        .in_ready (txq_ready),
        .in_data  (txq_data),
        .done     (tx_done),
        .txd      (txd)
    );

    flag_sync u_done_sync (
        .clk_a    (clk_uart),
        .clk_b    (clk_bus),
        .rst_n    (rst_n),
        .flag_in  (tx_done),
        .flag_out (tx_done_bus)
    );

    // ##################################################
    // Receive path
    // ##################################################

    uart_rx u_rx (
        .clk_uart  (clk_uart),
        .rst_n     (rst_n),
        .rxd       (rxd),
        .out_valid (rxr_valid),
        .out_data  (rxr_data)
    );

    cdc_handoff #(.payload_t(rx_result_t)) u_rx_handoff (
        .clk_src   (clk_uart),
        .clk_dst   (clk_bus),
        .rst_n     (rst_n),
        .src_valid (rxr_valid),
        .src_ready (),                     // Receiver cannot stall.
        .src_data  (rxr_data),
        .dst_valid (st_valid),
        .dst_ready (st_ready),
        .dst_data  (st_data),
        .drop      (rx_drop)
    );

    flag_sync u_drop_sync (
        .clk_a    (clk_uart),
        .clk_b    (clk_bus),
        .rst_n    (rst_n),
        .flag_in  (rx_drop),
        .flag_out (rx_drop_bus)
    );

    uart_status u_status (
        .clk_bus      (clk_bus),
        .rst_n        (rst_n),
        .res_valid    (st_valid),
        .res_ready    (st_ready),
        .res_data     (st_data),
        .drop         (rx_drop_bus),
        .tx_pending   (!tx_ready),
        .rx_valid     (rx_valid),
        .rx_ready     (rx_ready),
        .rx_data      (rx_data),
        .rx_frame_err (rx_frame_err),
        .err_clear    (err_clear),
        .tx_busy      (tx_busy),
        .overrun      (overrun),
        .frame_err    (frame_err)
    );

endmodule

`default_nettype wire

// File: tests/uart_core_tb.sv
`default_nettype none

module uart_core_tb
    import uart_pkg::*;
();

    localparam int BUS_PERIOD   = 100;
    localparam int UART_PERIOD  = 70;
    localparam int DRIVE_DLY    = 10;
    localparam int RESET_CYCLES = 4;
    localparam int BIT_TIME     = CLKS_PER_BIT * UART_PERIOD;
    localparam int FRAME_TIME   = FRAME_BITS * BIT_TIME;
    localparam int MID_OFFSET   = BIT_TIME / 2 + 10;         // Clear of both clock edges.
    localparam int WAIT_LIMIT   = 3 * FRAME_TIME / BUS_PERIOD;
    localparam int BURST        = 16;
    localparam int NUM_FRAMES   = 1 + BURST + 2 + 1 + 1;
    localparam int WD_TIME      = NUM_FRAMES * (FRAME_TIME + 30 * BUS_PERIOD)
                                  + 200 * BUS_PERIOD;

    logic       clk_bus = 1'b0;
    logic       clk_uart = 1'b0;
    logic       rst_n;
    logic       tx_valid;
    logic       tx_ready;
    uart_byte_t tx_data;
    logic       rx_valid;
    logic       rx_ready;
    uart_byte_t rx_data;
    logic       rx_frame_err;
    logic       err_clear;
    logic       tx_busy;
    logic       overrun;
    logic       frame_err;
    logic       txd;
    logic       rxd;
    logic       loopback;
    logic       line_drv;

    int         errors = 0;
    integer     seed = 64306;
    uart_byte_t burst [BURST];

    always #(BUS_PERIOD / 2) clk_bus = !clk_bus;
    always #(UART_PERIOD / 2) clk_uart = !clk_uart;

    assign rxd = loopback ? txd : line_drv;                  // Serial line select.

    uart_core i_dut (
        .clk_bus      (clk_bus),
        .clk_uart     (clk_uart),
        .rst_n        (rst_n),
        .tx_valid     (tx_valid),
        .tx_ready     (tx_ready),
        .tx_data      (tx_data),
        .rx_valid     (rx_valid),
        .rx_ready     (rx_ready),
        .rx_data      (rx_data),
        .rx_frame_err (rx_frame_err),
        .err_clear    (err_clear),
        .tx_busy      (tx_busy),
        .overrun      (overrun),
        .frame_err    (frame_err),
        .txd          (txd),
        .rxd          (rxd)
    );

    // ##################################################
    // Helpers
    // ##################################################

    task automatic next_cycle();
        @(posedge clk_bus);
        #(DRIVE_DLY);
    endtask

    task automatic check_byte(input string name, input uart_byte_t got, input uart_byte_t exp);
        if (got !== exp) begin
            errors++;
            $display("ERR %s: got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("ERR %s: got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_idle_outputs();
        check_bit("txd", txd, STOP_BIT);
        check_bit("tx_ready", tx_ready, 1'b1);
        check_bit("rx_valid", rx_valid, 1'b0);
        check_bit("tx_busy", tx_busy, 1'b0);
        check_bit("overrun", overrun, 1'b0);
        check_bit("frame_err", frame_err, 1'b0);
    endtask

    // Holds tx_valid until the transfer edge.
    task automatic send_byte(input uart_byte_t data);
        int waited;
        waited   = 0;
        tx_valid = 1'b1;
        tx_data  = data;
        while (!tx_ready && waited < WAIT_LIMIT) begin
            next_cycle();
            waited++;
        end
        if (!tx_ready) begin
            errors++;
            $display("Timeout: tx_ready stayed low with byte %h waiting", data);
        end
        next_cycle();
        tx_valid = 1'b0;
    endtask

    task automatic check_txd_frame(input uart_byte_t exp);
        @(negedge txd);
        #(MID_OFFSET);
        check_bit("txd start", txd, START_BIT);
        check_bit("tx_ready", tx_ready, 1'b0);
        check_bit("tx_busy", tx_busy, 1'b1);
        for (int i = 0; i < DATA_BITS; i++) begin
            #(BIT_TIME);
            check_bit("txd data", txd, exp[i]);
            check_bit("tx_ready", tx_ready, 1'b0);
        end
        #(BIT_TIME);
        check_bit("txd stop", txd, STOP_BIT);
        check_bit("tx_ready", tx_ready, 1'b0);
        check_bit("tx_busy", tx_busy, 1'b1);
    endtask

    task automatic drive_frame(input uart_byte_t data, input logic stop);
        line_drv = START_BIT;
        #(BIT_TIME);
        for (int i = 0; i < DATA_BITS; i++) begin
            line_drv = data[i];
            #(BIT_TIME);
        end
        line_drv = stop;
        #(BIT_TIME);
        line_drv = STOP_BIT;
    endtask

    task automatic wait_rx();
        int waited;
        waited = 0;
        while (!rx_valid && waited < WAIT_LIMIT) begin
            next_cycle();
            waited++;
        end
        if (!rx_valid) begin
            errors++;
            $display("Timeout: no result came out on rx_valid");
        end
    endtask

    task automatic wait_overrun();
        int waited;
        waited = 0;
        while (!overrun && waited < WAIT_LIMIT) begin
            next_cycle();
            waited++;
        end
        if (!overrun) begin
            errors++;
            $display("Timeout: overrun flag never set");
        end
    endtask

    // ##################################################
    // Tests
    // ##################################################

    task automatic single_byte_loopback();
        send_byte(8'hA5);
        check_txd_frame(8'hA5);
        next_cycle();
        wait_rx();
        check_byte("rx_data", rx_data, 8'hA5);
        check_bit("rx_frame_err", rx_frame_err, 1'b0);
        next_cycle();
    endtask

    task automatic random_burst();
        for (int i = 0; i < BURST; i++) begin
            burst[i] = uart_byte_t'($random(seed));
        end
        fork
            begin
                for (int i = 0; i < BURST; i++) begin
                    send_byte(burst[i]);
                end
            end
            begin
                for (int i = 0; i < BURST; i++) begin
                    check_txd_frame(burst[i]);
                end
            end
            begin
                for (int i = 0; i < BURST; i++) begin
                    wait_rx();
                    check_byte("rx_data", rx_data, burst[i]);
                    check_bit("rx_frame_err", rx_frame_err, 1'b0);
                    next_cycle();                            // Consumed here.
                end
            end
        join
        check_bit("overrun", overrun, 1'b0);
        check_bit("frame_err", frame_err, 1'b0);
    endtask

    task automatic overrun_unread();
        rx_ready = 1'b0;
        send_byte(8'h3C);
        send_byte(8'hC3);
        wait_overrun();
        check_bit("rx_valid", rx_valid, 1'b1);
        check_byte("rx_data", rx_data, 8'h3C);                 // First byte kept.
        check_bit("frame_err", frame_err, 1'b0);
        err_clear = 1'b1;
        next_cycle();
        err_clear = 1'b0;
        check_bit("overrun", overrun, 1'b0);
        rx_ready = 1'b1;
        next_cycle();
        check_bit("rx_valid", rx_valid, 1'b0);
    endtask

    task automatic framing_error();
        loopback = 1'b0;
        rx_ready = 1'b0;
        drive_frame(8'h5A, 1'b0);
        next_cycle();
        wait_rx();
        check_byte("rx_data", rx_data, 8'h5A);
        check_bit("rx_frame_err", rx_frame_err, 1'b1);
        check_bit("frame_err", frame_err, 1'b1);
        check_bit("overrun", overrun, 1'b0);
        rx_ready  = 1'b1;
        err_clear = 1'b1;
        next_cycle();
        err_clear = 1'b0;
        check_bit("rx_valid", rx_valid, 1'b0);
        check_bit("frame_err", frame_err, 1'b0);
        loopback = 1'b1;
    endtask

    task automatic reset_during_frame();
        send_byte(8'h96);
        @(negedge txd);
        repeat (20) next_cycle();                            // A few bits into the frame.
        rst_n = 1'b0;
        next_cycle();
        check_idle_outputs();
        repeat (RESET_CYCLES - 1) next_cycle();
        rst_n = 1'b1;
        next_cycle();
        check_idle_outputs();
    endtask

    // ##################################################
    // Main sequence and watchdog
    // ##################################################

    initial begin
        rst_n     = 1'b0;
        tx_valid  = 1'b0;
        tx_data   = '0;
        rx_ready  = 1'b1;
        err_clear = 1'b0;
        loopback  = 1'b1;
        line_drv  = STOP_BIT;
        repeat (RESET_CYCLES) next_cycle();
        rst_n = 1'b1;
        next_cycle();

        check_idle_outputs();
        single_byte_loopback();
        random_burst();
        overrun_unread();
        framing_error();
        reset_during_frame();

        $display("Run complete with %0d failed checks", errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    initial begin
        #(WD_TIME);
        $display("Watchdog expired at %0t with %0d failed checks", $time, errors);
        $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

// File: uart_core.f
hdl/uart_pkg.sv
hdl/flag_sync.sv
hdl/cdc_handoff.sv
hdl/uart_tx.sv
hdl/uart_rx.sv
hdl/uart_status.sv
hdl/uart_core.sv
tests/uart_core_tb.sv
